/* emu_cfg_pkg.sv */
package emu_cfg_pkg;

    // Token channels closed per target cycle
    localparam int NUM_CHAN = 2;

    // Bit positions in the channel vector
    localparam int CH_REQ  = 0;
    localparam int CH_RESP = 1;

    // One done flag per token channel
    typedef struct packed {
        logic req_done;
        logic resp_done;
    } chan_done_t;

endpackage

/* mem_req_pkg.sv */
package mem_req_pkg;

    localparam int ADDR_W = 8;   // Target word address
    localparam int DATA_W = 32;

    typedef struct packed {
        logic              is_write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] pad;
    } mem_rd_t;

    typedef struct packed {
        logic              is_write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_wr_t;

    // Same 41-bit word, read or write view by is_write
    typedef union packed {
        mem_rd_t rd;
        mem_wr_t wr;
    } mem_cmd_u;

    // Target request for one target cycle
    typedef struct packed {
        logic     valid;
        mem_cmd_u cmd;
    } tgt_req_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] rdata;
    } tgt_resp_t;

    // Host side strobes
    typedef struct packed {
        logic              valid;
        logic              is_write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } host_req_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] rdata;
    } host_resp_t;

endpackage

/* tick_scheduler.sv */
`timescale 1ns/100ps

module tick_scheduler (
    input  logic host_clk,
    input  logic tk_rst_fire,
    input  logic run_mode,
    input  logic tk_req_ready,
    output logic tk_req_valid,
    input  logic tk_resp_valid,
    output logic tk_resp_ready,
    output logic tick
);

    emu_cfg_pkg::chan_done_t done_q;

    logic req_fire;
    logic resp_fire;
    logic [emu_cfg_pkg::NUM_CHAN-1:0] chan_ok;

    // Request channel, scheduler is the producer
    assign tk_req_valid = run_mode && !done_q.req_done;
    assign req_fire     = tk_req_valid && tk_req_ready;

    // Response channel, scheduler is the consumer
    assign tk_resp_ready = run_mode && !done_q.resp_done;
    assign resp_fire     = tk_resp_valid && tk_resp_ready;

    assign chan_ok[emu_cfg_pkg::CH_REQ]  = req_fire || done_q.req_done;
    assign chan_ok[emu_cfg_pkg::CH_RESP] = resp_fire || done_q.resp_done;

    // Target cycle closes once every channel is through
    assign tick = run_mode && (&chan_ok);

    always_ff @(posedge host_clk) begin
        if (tk_rst_fire || tick) begin
            done_q <= '0;
        end else begin
            if (req_fire)
                done_q.req_done <= 1'b1;
            if (resp_fire)
                done_q.resp_done <= 1'b1;
        end
    end

    // Stopped model: no tick and no channel progress
    a_frozen_when_stopped: assert property (
        @(posedge host_clk) disable iff (tk_rst_fire)
        !run_mode |-> !tick ##1 $stable(done_q)
    );

endmodule

/* target_frontend.sv */
`timescale 1ns/100ps

module target_frontend (
    input  logic                   host_clk,
    input  logic                   tk_rst_fire,
    input  logic                   tick,
    input  mem_req_pkg::tgt_req_t  tgt_req,
    output mem_req_pkg::tgt_req_t  tk_req_data,
    input  mem_req_pkg::tgt_resp_t tk_resp_data,
    output mem_req_pkg::tgt_resp_t tgt_resp
);

    mem_req_pkg::tgt_req_t  req_q;
    mem_req_pkg::tgt_resp_t resp_q;

    // Target side state moves only on target clock edges
    always_ff @(posedge host_clk) begin
        if (tk_rst_fire) begin
            req_q.valid  <= 1'b0;   // First target cycle is a bubble
            resp_q.valid <= 1'b0;
        end else if (tick) begin
            req_q.valid  <= tgt_req.valid;
            resp_q.valid <= tk_resp_data.valid;
        end
    end

    always_ff @(posedge host_clk) begin
        if (tick) begin
            req_q.cmd    <= tgt_req.cmd;
            resp_q.rdata <= tk_resp_data.rdata;
        end
    end

    assign tk_req_data = req_q;   // Token for the next target cycle
    assign tgt_resp    = resp_q;

endmodule

/* emu_backend.sv */
`timescale 1ns/100ps

module emu_backend #(
    parameter int TGT_LAT = 2
) (
    input  logic                    host_clk,
    input  logic                    tk_rst_fire,
    input  logic                    tick,
    input  logic                    tk_req_valid,
    output logic                    tk_req_ready,
    input  mem_req_pkg::tgt_req_t   tk_req_data,
    output logic                    tk_resp_valid,
    input  logic                    tk_resp_ready,
    output mem_req_pkg::tgt_resp_t  tk_resp_data,
    output mem_req_pkg::host_req_t  host_req,
    input  mem_req_pkg::host_resp_t host_resp,
    input  logic                    host_busy,
    output logic                    idle
);

    localparam int PTR_W = (TGT_LAT > 1) ? $clog2(TGT_LAT) : 1;

    // One entry per target cycle in flight
    typedef struct packed {
        logic                           rd;     // Slot owes read data
        logic                           pend;   // Host data not back yet
        logic [mem_req_pkg::DATA_W-1:0] data;
    } slot_t;

    slot_t slot_q [TGT_LAT];

    logic [PTR_W-1:0] hd_q;       // Slot of the current target cycle
    logic [PTR_W-1:0] acc_slot_q;
    logic             acc_busy_q;
    logic             resp_vld_q;
    logic             resp_taken_q;
    logic             req_fire;
    logic             resp_fire;
    logic             new_rd;
    logic [TGT_LAT-1:0] rd_vec;

    mem_req_pkg::host_req_t host_q;
    mem_req_pkg::mem_cmd_u  cmd;

    assign cmd    = tk_req_data.cmd;
    assign new_rd = tk_req_data.valid && !cmd.rd.is_write;

    // Response token drains the slot before a new request may claim it
    assign resp_fire    = tk_resp_valid && tk_resp_ready;
    assign tk_req_ready = !acc_busy_q && (resp_taken_q || resp_fire);
    assign req_fire     = tk_req_valid && tk_req_ready;

    assign tk_resp_valid      = resp_vld_q;
    assign tk_resp_data.valid = slot_q[hd_q].rd;
    assign tk_resp_data.rdata = slot_q[hd_q].data;

    always_ff @(posedge host_clk) begin
        if (tk_rst_fire) begin
            resp_vld_q   <= 1'b0;
            resp_taken_q <= 1'b0;
            hd_q         <= '0;
        end else begin
            if (tick || resp_fire)
                resp_vld_q <= 1'b0;
            else if (!resp_taken_q && !slot_q[hd_q].pend)
                resp_vld_q <= 1'b1;   // Owed response is ready

            if (tick)
                resp_taken_q <= 1'b0;
            else if (resp_fire)
                resp_taken_q <= 1'b1;

            if (tick)
                hd_q <= (hd_q == PTR_W'(TGT_LAT - 1)) ? '0 : hd_q + 1'b1;
        end
    end

    always_ff @(posedge host_clk) begin
        if (tk_rst_fire) begin
            for (int i = 0; i < TGT_LAT; i++) begin
                slot_q[i].rd   <= 1'b0;
                slot_q[i].pend <= 1'b0;
            end
        end else begin
            if (host_resp.valid && !host_q.is_write) begin
                slot_q[acc_slot_q].pend <= 1'b0;
                slot_q[acc_slot_q].data <= host_resp.rdata;
            end
            if (req_fire) begin   // Writes and bubbles leave an empty slot
                slot_q[hd_q].rd   <= new_rd;
                slot_q[hd_q].pend <= new_rd;
            end
        end
    end

    // Host access sequencing
    always_ff @(posedge host_clk) begin
        if (tk_rst_fire) begin
            acc_busy_q   <= 1'b0;
            host_q.valid <= 1'b0;
        end else begin
            if (host_req.valid)
                host_q.valid <= 1'b0;
            if (host_resp.valid)
                acc_busy_q <= 1'b0;
            if (req_fire && tk_req_data.valid) begin
                acc_busy_q   <= 1'b1;
                host_q.valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge host_clk) begin
        if (req_fire) begin
            host_q.is_write <= cmd.rd.is_write;
            host_q.addr     <= cmd.rd.addr;   // Same field in both views
            if (cmd.rd.is_write)
                host_q.wdata <= cmd.wr.wdata;
            else
                host_q.wdata <= '0;
            acc_slot_q <= hd_q;
        end
    end

    always_comb begin
        host_req       = host_q;
        host_req.valid = host_q.valid && !host_busy;   // Wait out the memory
    end

    always_comb begin
        for (int i = 0; i < TGT_LAT; i++)
            rd_vec[i] = slot_q[i].rd;
    end

    assign idle = !acc_busy_q && !(|rd_vec);

    a_resp_hold: assert property (
        @(posedge host_clk) disable iff (tk_rst_fire)
        tk_resp_valid && !tk_resp_ready |=> tk_resp_valid
    );

    // Completion only for an access already handed to the memory
    a_resp_expected: assert property (
        @(posedge host_clk) disable iff (tk_rst_fire)
        host_resp.valid |-> acc_busy_q && !host_q.valid
    );

endmodule

/* host_mem.sv */
`timescale 1ns/100ps

module host_mem #(
    parameter int HOST_LAT_BASE = 2
) (
    input  logic                    host_clk,
    input  logic                    tk_rst_fire,
    input  mem_req_pkg::host_req_t  host_req,
    output mem_req_pkg::host_resp_t host_resp,
    output logic                    host_busy
);

    localparam int DEPTH = 2 ** mem_req_pkg::ADDR_W;
    localparam int LAT_W = $clog2(HOST_LAT_BASE + 4);

    logic [mem_req_pkg::DATA_W-1:0] mem_q [DEPTH];

    logic [mem_req_pkg::ADDR_W-1:0] clr_cnt_q;
    logic                           clr_act_q;
    logic                           busy_q;
    logic [LAT_W-1:0]               lat_q;
    logic                           done;
    logic                           acc_write_q;
    logic [mem_req_pkg::ADDR_W-1:0] acc_addr_q;
    logic [mem_req_pkg::DATA_W-1:0] acc_wdata_q;

    assign host_busy = busy_q || clr_act_q;
    assign done      = busy_q && (lat_q == LAT_W'(1));   // Last latency cycle

    always_ff @(posedge host_clk) begin
        if (tk_rst_fire) begin
            clr_act_q <= 1'b1;
            clr_cnt_q <= '0;
            busy_q    <= 1'b0;
            lat_q     <= '0;
        end else begin
            if (clr_act_q) begin
                clr_cnt_q <= clr_cnt_q + 1'b1;
                if (clr_cnt_q == '1)
                    clr_act_q <= 1'b0;
            end

            if (host_req.valid && !host_busy) begin
                busy_q <= 1'b1;
                // Low address bits pick the bank delay
                lat_q  <= LAT_W'(HOST_LAT_BASE) + LAT_W'(host_req.addr[1:0]);
            end else if (done) begin
                busy_q <= 1'b0;
            end else if (busy_q) begin
                lat_q <= lat_q - 1'b1;
            end
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_req.valid && !host_busy) begin
            acc_write_q <= host_req.is_write;
            acc_addr_q  <= host_req.addr;
            acc_wdata_q <= host_req.wdata;
        end
    end

    // One word per cycle while clearing
    always_ff @(posedge host_clk) begin
        if (clr_act_q)
            mem_q[clr_cnt_q] <= '0;
        else if (done && acc_write_q)
            mem_q[acc_addr_q] <= acc_wdata_q;
    end

    assign host_resp.valid = done;
    assign host_resp.rdata = mem_q[acc_addr_q];

    a_no_req_busy: assert property (
        @(posedge host_clk) disable iff (tk_rst_fire)
        host_req.valid |-> !host_busy
    );

endmodule

/* emu_ram_top.sv */
`timescale 1ns/100ps

module emu_ram_top #(
    parameter int TGT_LAT       = 2,
    parameter int HOST_LAT_BASE = 2
) (
    input  logic                   host_clk,
    input  logic                   tk_rst_fire,
    input  logic                   run_mode,
    input  mem_req_pkg::tgt_req_t  tgt_req,
    output mem_req_pkg::tgt_resp_t tgt_resp,
    output logic                   tgt_tick,
    output logic                   idle
);

    logic tick;
    logic tk_req_valid;
    logic tk_req_ready;
    logic tk_resp_valid;
    logic tk_resp_ready;
    logic host_busy;

    mem_req_pkg::tgt_req_t   tk_req_data;
    mem_req_pkg::tgt_resp_t  tk_resp_data;
    mem_req_pkg::host_req_t  host_req;
    mem_req_pkg::host_resp_t host_resp;

    tick_scheduler u_sched (
        .host_clk      (host_clk),
        .tk_rst_fire   (tk_rst_fire),
        .run_mode      (run_mode),
        .tk_req_ready  (tk_req_ready),
        .tk_req_valid  (tk_req_valid),
        .tk_resp_valid (tk_resp_valid),
        .tk_resp_ready (tk_resp_ready),
        .tick          (tick)
    );

    target_frontend u_front (
        .host_clk     (host_clk),
        .tk_rst_fire  (tk_rst_fire),
        .tick         (tick),
        .tgt_req      (tgt_req),
        .tk_req_data  (tk_req_data),
        .tk_resp_data (tk_resp_data),
        .tgt_resp     (tgt_resp)
    );

    emu_backend #(
        .TGT_LAT (TGT_LAT)
    ) u_backend (
        .host_clk      (host_clk),
        .tk_rst_fire   (tk_rst_fire),
        .tick          (tick),
        .tk_req_valid  (tk_req_valid),
        .tk_req_ready  (tk_req_ready),
        .tk_req_data   (tk_req_data),
        .tk_resp_valid (tk_resp_valid),
        .tk_resp_ready (tk_resp_ready),
        .tk_resp_data  (tk_resp_data),
        .host_req      (host_req),
        .host_resp     (host_resp),
        .host_busy     (host_busy),
        .idle          (idle)
    );

    host_mem #(
        .HOST_LAT_BASE (HOST_LAT_BASE)
    ) u_mem (
        .host_clk    (host_clk),
        .tk_rst_fire (tk_rst_fire),
        .host_req    (host_req),
        .host_resp   (host_resp),
        .host_busy   (host_busy)
    );

    assign tgt_tick = tick;   // Target clock enable

endmodule

/* tb_emu_ram.sv */
`timescale 1ns/100ps

module tb_emu_ram;

    localparam int TGT_LAT       = 2;
    localparam int HOST_LAT_BASE = 2;
    localparam int ADDR_W        = mem_req_pkg::ADDR_W;
    localparam int DATA_W        = mem_req_pkg::DATA_W;
    localparam int MAX_TICKS     = 512;
    localparam int WAIT_LIMIT    = 200;   // Host cycles per wait

    logic                   host_clk;
    logic                   tk_rst_fire;
    logic                   run_mode;
    mem_req_pkg::tgt_req_t  tgt_req;
    mem_req_pkg::tgt_resp_t tgt_resp;
    logic                   tgt_tick;
    logic                   idle;

    logic [DATA_W-1:0] ref_mem [2 ** ADDR_W];
    logic              exp_valid [MAX_TICKS];   // Indexed by target cycle
    logic [DATA_W-1:0] exp_rdata [MAX_TICKS];

    int     tick_cnt = 0;
    int     last_due;
    integer seed;

    emu_ram_top #(
        .TGT_LAT       (TGT_LAT),
        .HOST_LAT_BASE (HOST_LAT_BASE)
    ) i_dut (
        .host_clk    (host_clk),
        .tk_rst_fire (tk_rst_fire),
        .run_mode    (run_mode),
        .tgt_req     (tgt_req),
        .tgt_resp    (tgt_resp),
        .tgt_tick    (tgt_tick),
        .idle        (idle)
    );

    initial begin
        host_clk = 1'b0;
        forever #10 host_clk = ~host_clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] addr);
        return ref_mem[addr];
    endfunction

    // What the target should see for this request, before it updates the memory
    function automatic mem_req_pkg::tgt_resp_t expected_resp(input mem_req_pkg::tgt_req_t req);
        mem_req_pkg::tgt_resp_t resp;
        resp = '0;
        if (req.valid && !req.cmd.rd.is_write) begin
            resp.valid = 1'b1;
            resp.rdata = ref_read(req.cmd.rd.addr);
        end
        return resp;
    endfunction

    task automatic check_resp(input int idx);
        if (idx >= MAX_TICKS) begin
            stop_on_error("Target cycle count ran past the expected response table");
        end else begin
            assert (tgt_resp.valid == exp_valid[idx]) else
                stop_on_error($sformatf("ERROR tgt_resp.valid at tick %0d: got %h, expected %h",
                                        idx, tgt_resp.valid, exp_valid[idx]));
            if (exp_valid[idx]) begin
                assert (tgt_resp.rdata == exp_rdata[idx]) else
                    stop_on_error($sformatf("ERROR tgt_resp.rdata at tick %0d: got %h, expected %h",
                                            idx, tgt_resp.rdata, exp_rdata[idx]));
            end
        end
    endtask

    // Tick counter and response compare
    initial begin
        forever begin
            @(negedge host_clk);
            assert (run_mode || !tgt_tick) else
                stop_on_error("A target tick occurred while run_mode was low");
            if (!tk_rst_fire && tgt_tick) begin
                @(posedge host_clk);
                #1;
                check_resp(tick_cnt);
                tick_cnt++;
            end
        end
    end

    // Holds one request until the tick that samples it
    task automatic issue(input mem_req_pkg::tgt_req_t req);
        mem_req_pkg::tgt_resp_t exp;
        int wait_cnt;
        int due;
        tgt_req  = req;
        wait_cnt = 0;
        do begin
            @(negedge host_clk);
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT)
                stop_on_error("Timed out waiting for a target tick to take the request");
        end while (!tgt_tick);
        due = tick_cnt + 1 + TGT_LAT;   // Consumed next tick, answered TGT_LAT later
        exp = expected_resp(req);
        if (due < MAX_TICKS) begin
            exp_valid[due] = exp.valid;
            exp_rdata[due] = exp.rdata;
        end
        if (exp.valid)
            last_due = due;
        if (req.valid && req.cmd.wr.is_write)
            ref_mem[req.cmd.wr.addr] = req.cmd.wr.wdata;
        @(posedge host_clk);
        #2;
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        mem_req_pkg::tgt_req_t req;
        req                 = '0;
        req.valid           = 1'b1;
        req.cmd.wr.is_write = 1'b1;
        req.cmd.wr.addr     = addr;
        req.cmd.wr.wdata    = data;
        issue(req);
    endtask

    task automatic read_word(input logic [ADDR_W-1:0] addr);
        mem_req_pkg::tgt_req_t req;
        req             = '0;
        req.valid       = 1'b1;
        req.cmd.rd.addr = addr;
        issue(req);
    endtask

    task automatic send_bubble();
        issue('0);
    endtask

    // Stops the model for a while, target time must not move
    task automatic pause_run(input int cycles);
        int frozen;
        run_mode = 1'b0;
        frozen   = tick_cnt;
        repeat (cycles) @(posedge host_clk);
        #2;
        assert (tick_cnt == frozen) else
            stop_on_error($sformatf("ERROR tick count during pause: got %h, expected %h",
                                    tick_cnt, frozen));
        run_mode = 1'b1;
    endtask

    task automatic wait_idle();
        int wait_cnt;
        wait_cnt = 0;
        while (!idle) begin
            @(posedge host_clk);
            #2;
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT)
                stop_on_error("Timed out waiting for the backend to report idle");
        end
    endtask

    initial begin
        int                op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        int                drain;
        seed        = 32'h7a61_0bd0;
        last_due    = 0;
        tk_rst_fire = 1'b1;
        run_mode    = 1'b0;
        tgt_req     = '0;
        for (int i = 0; i < 2 ** ADDR_W; i++)
            ref_mem[i] = '0;
        for (int i = 0; i < MAX_TICKS; i++) begin
            exp_valid[i] = 1'b0;
            exp_rdata[i] = '0;
        end

        repeat (2) @(posedge host_clk);
        #2;
        tk_rst_fire = 1'b0;
        @(negedge host_clk);
        assert (idle) else
            stop_on_error($sformatf("ERROR idle after reset: got %h, expected %h", idle, 1'b1));
        assert (!tgt_resp.valid) else
            stop_on_error($sformatf("ERROR tgt_resp.valid after reset: got %h, expected %h",
                                    tgt_resp.valid, 1'b0));

        // Model stopped while the host memory clears
        repeat (300) @(posedge host_clk);
        #2;
        assert (tick_cnt == 0) else
            stop_on_error($sformatf("ERROR tick count while stopped: got %h, expected %h",
                                    tick_cnt, 0));
        run_mode = 1'b1;

        write_word(8'h05, 32'hdead_beef);
        read_word(8'h05);
        read_word(8'h40);   // Never written
        send_bubble();
        write_word(8'h13, 32'h0123_4567);
        send_bubble();
        read_word(8'h13);
        read_word(8'h05);
        write_word(8'h22, 32'h89ab_cdef);
        read_word(8'h22);
        read_word(8'h13);

        for (int n = 0; n < 48; n++) begin
            op   = $random(seed) & 7;
            addr = $random(seed) & 8'h1f;   // Low bits spread the host latency
            data = $random(seed);
            if (op == 0)
                send_bubble();
            else if (op < 4)
                write_word(addr, data);
            else
                read_word(addr);
        end

        // Reads left pending across the pauses
        read_word(8'h05);
        read_word(8'h13);
        pause_run(25);
        read_word(8'h22);
        read_word(8'h07);
        pause_run(10);
        read_word(8'h05);

        drain = 0;
        while (tick_cnt <= last_due) begin
            send_bubble();
            drain++;
            if (drain > 4 * TGT_LAT + 8)
                stop_on_error("Pending reads did not drain in the expected number of ticks");
        end
        wait_idle();

        $display(">>> PASS");
        $finish;
    end

endmodule

/* build.f */
emu_cfg_pkg.sv
mem_req_pkg.sv
tick_scheduler.sv
target_frontend.sv
emu_backend.sv
host_mem.sv
emu_ram_top.sv
tb_emu_ram.sv
